//--- src/ex_pkg.sv
package ex_pkg;

  typedef enum logic [3:0] {
    T_INH    = 4'd0,
    T_ALU    = 4'd1,
    T_CMP    = 4'd2,
    T_INT    = 4'd3,
    T_INTU   = 4'd4,
    T_LOAD   = 4'd5,
    T_STORE  = 4'd6,
    T_LDI    = 4'd7,
    T_MOV    = 4'd8,
    T_BRANCH = 4'd9,
    T_JUMP   = 4'd10
  } instr_type_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_ASR
  } alufunc_t;

  // bit 2 picks the unsigned form
  typedef enum logic [2:0] {
    INT_MUL   = 3'd0,
    INT_DIV   = 3'd1,
    INT_MOD   = 3'd2,
    INT_MULX  = 3'd3,
    INT_MULU  = 3'd4,
    INT_DIVU  = 3'd5,
    INT_MODU  = 3'd6,
    INT_MULXU = 3'd7
  } intfunc_t;

  typedef struct packed {
    instr_type_t itype;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [14:0] imm;
    logic        size;
  } instr_opnd_t;

  typedef struct packed {
    instr_type_t itype;
    logic [3:0]  op;
    logic [20:0] pad;
    logic [1:0]  trapno;
    logic        size;
  } instr_inh_t;

  typedef union packed {
    instr_opnd_t opnd;
    instr_inh_t  inh;
  } instr_lo_u;

  // condition register bits
  localparam int CCR_LTU = 2;
  localparam int CCR_LT  = 1;
  localparam int CCR_EQ  = 0;

  function automatic logic [31:0] imm_sext(input instr_lo_u lo);
    return {{17{lo.opnd.imm[14]}}, lo.opnd.imm};
  endfunction

  function automatic logic [31:0] imm_zext(input instr_lo_u lo);
    return {17'h0, lo.opnd.imm};
  endfunction

  function automatic logic [31:0] word_off(input instr_lo_u lo);
    logic [31:0] s;
    s = imm_sext(lo);
    return {s[29:0], 2'b00};
  endfunction

endpackage

//--- src/alu_if.sv
`timescale 1ns/100ps

interface alu_if import ex_pkg::*; ();

  logic [31:0] in1;
  logic [31:0] in2;
  alufunc_t    func;
  logic [31:0] out;
  logic        c;
  logic        z;
  logic        n;
  logic        v;

  modport exec (output in1, in2, func, input out, c, z, n, v);

  modport alu (input in1, in2, func, output out, c, z, n, v);

endinterface

//--- src/alu_comb.sv
`timescale 1ns/100ps

module alu_comb import ex_pkg::*; (
  alu_if.alu bus
);

  logic [32:0] sum;
  logic [32:0] diff;
  logic [31:0] res;

  assign sum  = {1'b0, bus.in1} + {1'b0, bus.in2};
  assign diff = {1'b0, bus.in1} - {1'b0, bus.in2}; // bit 32 is the borrow

  always_comb
  begin
    res   = 32'h0;
    bus.c = 1'b0;
    bus.v = 1'b0;
    case (bus.func)
      ALU_ADD:
      begin
        res   = sum[31:0];
        bus.c = sum[32];
        bus.v = (bus.in1[31] == bus.in2[31]) && (res[31] != bus.in1[31]);
      end
      ALU_SUB:
      begin
        res   = diff[31:0];
        bus.c = diff[32];
        bus.v = (bus.in1[31] != bus.in2[31]) && (res[31] != bus.in1[31]);
      end
      ALU_AND:
        res = bus.in1 & bus.in2;
      ALU_OR:
        res = bus.in1 | bus.in2;
      ALU_XOR:
        res = bus.in1 ^ bus.in2;
      ALU_SHL:
        res = bus.in1 << bus.in2[4:0];
      ALU_SHR:
        res = bus.in1 >> bus.in2[4:0];
      ALU_ASR:
        res = $unsigned($signed(bus.in1) >>> bus.in2[4:0]);
      default:
        res = 32'h0;
    endcase
  end

  assign bus.out = res;
  assign bus.z   = (res == 32'h0);
  assign bus.n   = res[31];

endmodule

//--- src/int_calc.sv
`timescale 1ns/100ps

module int_calc import ex_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  intfunc_t    func_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  output logic [31:0] result_o
);

  intfunc_t    func_q;
  logic [31:0] a_q;
  logic [31:0] b_q;
  logic        uns;
  logic [63:0] prod;
  logic [31:0] quot;
  logic [31:0] rem;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      func_q <= INT_MUL;
    else if (start_i)
      func_q <= func_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  assign uns = func_q[2];

  // low 64 bits of the extended product are right for both forms
  assign prod = uns ? {32'h0, a_q} * {32'h0, b_q}
                    : {{32{a_q[31]}}, a_q} * {{32{b_q[31]}}, b_q};

  always_comb
  begin
    if (b_q == 32'h0)
    begin
      quot = 32'hffffffff;
      rem  = a_q; // divide by zero
    end
    else if (uns)
    begin
      quot = a_q / b_q;
      rem  = a_q % b_q;
    end
    else
    begin
      quot = $unsigned($signed(a_q) / $signed(b_q));
      rem  = $unsigned($signed(a_q) % $signed(b_q));
    end
  end

  always_comb
  begin
    case (func_q[1:0])
      2'd0:    result_o = prod[31:0];
      2'd1:    result_o = quot;
      2'd2:    result_o = rem;
      default: result_o = prod[63:32]; // mulx
    endcase
  end

endmodule

//--- src/execute.sv
`timescale 1ns/100ps

module execute import ex_pkg::*; #(
  parameter int          INT_CYCLES = 4,
  parameter logic [31:0] VECT_RESET = 32'hffffffc0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [63:0] ir_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] reg_data1_i,
  input  logic [31:0] reg_data2_i,
  input  logic [1:0]  reg_write_i,
  input  logic        stall_i,
  output logic [31:0] result_o,
  output logic [31:0] reg_data1_o,
  output logic [31:0] pc_o,
  output logic [63:0] ir_o,
  output logic [1:0]  reg_write_o,
  output logic [2:0]  ccr_o,
  output logic        halt_o,
  output logic        stall_o,
  output logic        interrupts_enabled_o,
  output logic        exc_o,
  output logic        pc_set_o,
  alu_if.exec         alu
);

  localparam int CW = $clog2(INT_CYCLES + 1);

  instr_lo_u   lo;
  instr_type_t itype;
  logic [3:0]  op;
  logic        size;
  logic [31:0] ext;
  logic [31:0] sval;
  logic [31:0] off;
  logic [31:0] op2;

  logic [CW-1:0] delay;
  logic          stall_start;
  logic          hold;
  intfunc_t      int_func;
  logic [31:0]   int_res;

  logic [31:0] vect_base;
  logic [31:0] result_next;
  logic [31:0] pc_next;
  logic [2:0]  ccr_next;
  logic        exc_next;
  logic        pc_set_next;
  logic        taken;
  logic        halt_next;
  logic        ie_next;
  logic [31:0] base_next;

  assign lo    = ir_i[31:0];
  assign itype = lo.opnd.itype;
  assign op    = lo.opnd.op;
  assign size  = lo.opnd.size;
  assign ext   = ir_i[63:32];
  assign sval  = imm_sext(lo);
  assign off   = word_off(lo);
  assign op2   = op[3] ? sval : reg_data2_i; // immediate form

  assign stall_start = (itype == T_INT || itype == T_INTU) && (delay == '0);
  assign stall_o     = (delay > CW'(1)) || stall_start;
  assign hold        = stall_i || stall_o;

  assign int_func = intfunc_t'({itype == T_INTU, op[1:0]});

  int_calc int_calc_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (stall_start),
    .func_i   (int_func),
    .a_i      (reg_data1_i),
    .b_i      (op2),
    .result_o (int_res)
  );

  always_comb
  begin
    alu.in1  = reg_data1_i;
    alu.in2  = reg_data2_i;
    alu.func = alufunc_t'(op[2:0]);
    case (itype)
      T_ALU:
        alu.in2 = op2;
      T_CMP:
        alu.func = ALU_SUB;
      T_LOAD, T_STORE, T_JUMP:
      begin
        alu.in1  = off; // offset plus reg_data2
        alu.func = ALU_ADD;
      end
      T_BRANCH:
      begin
        alu.in1  = pc_i;
        alu.in2  = off;
        alu.func = ALU_ADD;
      end
      default:
      begin
      end
    endcase
  end

  assign ccr_next = (itype == T_CMP) ? {alu.c, alu.n ^ alu.v, alu.z} : ccr_o;

  always_comb
  begin
    result_next = alu.out;
    exc_next    = 1'b0;
    case (itype)
      T_INH:
        if (op == 4'h5)
        begin
          result_next = vect_base; // reset vector
          exc_next    = 1'b1;
        end
        else if (op == 4'h1 && !size)
        begin
          result_next = vect_base + 32'd24 + {27'h0, lo.inh.trapno, 3'h0};
          exc_next    = 1'b1;
        end
      T_INT, T_INTU:
        result_next = int_res;
      T_LOAD, T_STORE:
        if (size)
          result_next = ext;
      T_LDI:
        result_next = size ? ext : imm_zext(lo);
      T_MOV:
        result_next = reg_data1_i;
      default:
      begin
      end
    endcase
  end

  always_comb
  begin
    case (op)
      4'h0:    taken = 1'b1;
      4'h1:    taken = ccr_o[CCR_EQ];
      4'h2:    taken = !ccr_o[CCR_EQ];
      4'h3:    taken = !(ccr_o[CCR_LTU] || ccr_o[CCR_EQ]);
      4'h4:    taken = !(ccr_o[CCR_LT] || ccr_o[CCR_EQ]);
      4'h5:    taken = !ccr_o[CCR_LT];
      4'h6:    taken = ccr_o[CCR_LT] || ccr_o[CCR_EQ];
      4'h7:    taken = ccr_o[CCR_LT];
      4'h8:    taken = !ccr_o[CCR_LTU];
      4'h9:    taken = ccr_o[CCR_LTU];
      4'ha:    taken = ccr_o[CCR_LTU] || ccr_o[CCR_EQ];
      default: taken = 1'b0;
    endcase
  end

  always_comb
  begin
    pc_next     = pc_i;
    pc_set_next = 1'b0;
    if (itype == T_BRANCH && taken)
    begin
      pc_next     = alu.out;
      pc_set_next = 1'b1;
    end
    else if (itype == T_JUMP)
    begin
      pc_next     = size ? ext : alu.out;
      pc_set_next = 1'b1;
    end
  end

  always_comb
  begin
    halt_next = halt_o;
    ie_next   = interrupts_enabled_o;
    base_next = vect_base;
    if (itype == T_INH)
    begin
      case (op)
        4'h1:
          if (size)
            base_next = ext; // setint
        4'h2:
          ie_next = 1'b0;
        4'h3:
          ie_next = 1'b1;
        4'h4:
          halt_next = 1'b1;
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ir_o                 <= 64'h0;
      pc_o                 <= 32'h0;
      reg_data1_o          <= 32'h0;
      reg_write_o          <= 2'h0;
      result_o             <= 32'h0;
      ccr_o                <= 3'h0;
      pc_set_o             <= 1'b0;
      exc_o                <= 1'b0;
      halt_o               <= 1'b0;
      interrupts_enabled_o <= 1'b0;
      vect_base            <= VECT_RESET;
      delay                <= '0;
    end
    else
    begin
      if (stall_start)
        delay <= CW'(INT_CYCLES);
      else if (delay != '0)
        delay <= delay - CW'(1);

      if (!hold)
      begin
        ir_o        <= ir_i;
        pc_o        <= pc_next;
        reg_data1_o <= reg_data1_i;
        reg_write_o <= reg_write_i;
        result_o    <= result_next;
        ccr_o       <= ccr_next;
        pc_set_o    <= pc_set_next;
        exc_o       <= exc_next;
      end

      if (!stall_i)
      begin
        halt_o               <= halt_next;
        interrupts_enabled_o <= ie_next;
        vect_base            <= base_next;
      end
    end
  end

endmodule

//--- src/ex_top.sv
`timescale 1ns/100ps

module ex_top #(
  parameter int          INT_CYCLES = 4,
  parameter logic [31:0] VECT_RESET = 32'hffffffc0
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [63:0] ir_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] reg_data1_i,
  input  logic [31:0] reg_data2_i,
  input  logic [1:0]  reg_write_i,
  input  logic        stall_i,
  output logic [31:0] result_o,
  output logic [31:0] reg_data1_o,
  output logic [31:0] pc_o,
  output logic [63:0] ir_o,
  output logic [1:0]  reg_write_o,
  output logic [2:0]  ccr_o,
  output logic        halt_o,
  output logic        stall_o,
  output logic        interrupts_enabled_o,
  output logic        exc_o,
  output logic        pc_set_o
);

  alu_if alu_bus ();

  execute #(
    .INT_CYCLES (INT_CYCLES),
    .VECT_RESET (VECT_RESET)
  ) execute_inst (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .ir_i                 (ir_i),
    .pc_i                 (pc_i),
    .reg_data1_i          (reg_data1_i),
    .reg_data2_i          (reg_data2_i),
    .reg_write_i          (reg_write_i),
    .stall_i              (stall_i),
    .result_o             (result_o),
    .reg_data1_o          (reg_data1_o),
    .pc_o                 (pc_o),
    .ir_o                 (ir_o),
    .reg_write_o          (reg_write_o),
    .ccr_o                (ccr_o),
    .halt_o               (halt_o),
    .stall_o              (stall_o),
    .interrupts_enabled_o (interrupts_enabled_o),
    .exc_o                (exc_o),
    .pc_set_o             (pc_set_o),
    .alu                  (alu_bus.exec)
  );

  alu_comb alu_comb_inst (
    .bus (alu_bus.alu)
  );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
  parameter int HALF_PERIOD = 4,
  parameter int RST_CYCLES  = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // released away from the rising edge
  end

endmodule

//--- dv/ex_checker.sv
`timescale 1ns/100ps

module ex_checker import ex_pkg::*; #(
  parameter int INT_CYCLES = 4
) (
  input logic        clk_i,
  input logic        rst_i,
  input logic [63:0] ir_i,
  input logic        stall_i,
  input logic        stall_o,
  input logic        halt_o,
  input logic        pc_set_o
);

  logic [3:0] itype;
  int         stall_run; // high samples before this edge

  assign itype = ir_i[31:28];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      stall_run <= 0;
    else if (stall_o)
      stall_run <= stall_run + 1;
    else
      stall_run <= 0;
  end

  // upstream holds the integer instruction for the whole stall
  stall_needs_int: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_o |-> (itype == T_INT || itype == T_INTU))
    else $error("stall_o high without an integer instruction");

  stall_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_o |-> stall_run < INT_CYCLES)
    else $error("stall_o high for more than INT_CYCLES cycles");

  halt_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    !$fell(halt_o))
    else $error("halt_o fell without reset");

  // only edges that captured an instruction
  redirect_after_flow: assert property (@(posedge clk_i) disable iff (rst_i)
    ($past(!(stall_i || stall_o)) && pc_set_o)
      |-> $past(itype == T_BRANCH || itype == T_JUMP))
    else $error("pc_set_o high without a branch or jump");

endmodule

//--- dv/ex_tb.sv
`timescale 1ns/100ps

module ex_tb import ex_pkg::*; ();

  localparam int          INT_CYCLES = 4;
  localparam logic [31:0] VECT_RESET = 32'hffffffc0;
  localparam int N_SIMPLE = 200;
  localparam int N_BRANCH = 4; // rounds of 11 compare/branch pairs and 4 jumps
  localparam int N_INT    = 64;
  localparam int N_INH    = 13;
  localparam int N_STALL  = 100;
  localparam int N_INSTR  = N_SIMPLE + N_BRANCH * 26 + N_INT + N_INH + N_STALL;
  localparam int WATCHDOG_CYCLES = N_INSTR * (INT_CYCLES + 2) + 50;

  logic        clk;
  logic        rst;
  logic [63:0] ir;
  logic [31:0] pc;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [1:0]  rw;
  logic        stall;
  logic [31:0] result;
  logic [31:0] rd1_out;
  logic [31:0] pc_out;
  logic [63:0] ir_out;
  logic [1:0]  rw_out;
  logic [2:0]  ccr;
  logic        halt;
  logic        stall_out;
  logic        ie;
  logic        exc;
  logic        pc_set;

  logic [31:0] rng_state;
  logic [2:0]  m_ccr;
  logic [31:0] m_base;
  logic        m_ie;
  logic        m_halt;
  logic [63:0] exp_ir;
  logic [31:0] exp_pc;
  logic [31:0] exp_rd1;
  logic [1:0]  exp_rw;
  logic [31:0] exp_result;
  logic        exp_rvalid; // result defined for this type
  logic        exp_pcset;
  logic        exp_exc;

  clk_gen clk_gen_inst (
    .clk_o (clk),
    .rst_o (rst)
  );

  ex_top ex_top_inst (
    .clk_i                (clk),
    .rst_i                (rst),
    .ir_i                 (ir),
    .pc_i                 (pc),
    .reg_data1_i          (rd1),
    .reg_data2_i          (rd2),
    .reg_write_i          (rw),
    .stall_i              (stall),
    .result_o             (result),
    .reg_data1_o          (rd1_out),
    .pc_o                 (pc_out),
    .ir_o                 (ir_out),
    .reg_write_o          (rw_out),
    .ccr_o                (ccr),
    .halt_o               (halt),
    .stall_o              (stall_out),
    .interrupts_enabled_o (ie),
    .exc_o                (exc),
    .pc_set_o             (pc_set)
  );

  bind execute ex_checker #(.INT_CYCLES(INT_CYCLES)) ex_checker_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .ir_i     (ir_i),
    .stall_i  (stall_i),
    .stall_o  (stall_o),
    .halt_o   (halt_o),
    .pc_set_o (pc_set_o)
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] make_instr(input logic [3:0] ty, input logic [3:0] op);
    logic [31:0] r;
    r = xorshift32();
    return {xorshift32(), ty, op, r[23:0]};
  endfunction

  function automatic logic [63:0] inh_instr(input logic [3:0] op, input logic [1:0] tn,
                                            input logic sz);
    return {xorshift32(), 4'h0, op, 21'h0, tn, sz};
  endfunction

  function automatic logic [63:0] rand_simple(input logic with_cmp);
    logic [31:0] r;
    logic [3:0]  ty;
    r = xorshift32();
    case (r % 32'd6)
      0:       ty = T_ALU;
      1:       ty = T_LDI;
      2:       ty = T_MOV;
      3:       ty = T_LOAD;
      4:       ty = T_STORE;
      default: ty = with_cmp ? T_CMP : T_ALU;
    endcase
    return make_instr(ty, r[11:8]);
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f)
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      3'd5:    return a << b[4:0];
      3'd6:    return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  function automatic logic [31:0] int_model(input logic [2:0] f, input logic [31:0] a,
                                            input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        p;
    logic [31:0]        q;
    logic [31:0]        m;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    if (f[2])
    begin
      p = {32'h0, a} * {32'h0, b};
      q = (b == 32'h0) ? 32'hffffffff : a / b;
      m = (b == 32'h0) ? a : a % b;
    end
    else
    begin
      p = sa * sb; // 64-bit signed product cannot overflow
      q = (b == 32'h0) ? 32'hffffffff : 32'(sa / sb);
      m = (b == 32'h0) ? a : 32'(sa % sb);
    end
    case (f[1:0])
      2'd0:    return p[31:0];
      2'd1:    return q;
      2'd2:    return m;
      default: return p[63:32];
    endcase
  endfunction

  function automatic logic cond_met(input logic [3:0] op, input logic [2:0] c);
    logic ltu;
    logic lt;
    logic eq;
    ltu = c[CCR_LTU];
    lt  = c[CCR_LT];
    eq  = c[CCR_EQ];
    case (op)
      4'd0:    return 1'b1;
      4'd1:    return eq;
      4'd2:    return !eq;
      4'd3:    return !ltu && !eq;
      4'd4:    return !lt && !eq;
      4'd5:    return !lt;
      4'd6:    return lt || eq;
      4'd7:    return lt;
      4'd8:    return !ltu;
      4'd9:    return ltu;
      4'd10:   return ltu || eq;
      default: return 1'b0;
    endcase
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want)
      fail_stop($sformatf("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, want));
  endtask

  task automatic drive(input logic [63:0] instr);
    ir  = instr;
    pc  = xorshift32() & 32'hfffffffc;
    rd1 = xorshift32();
    rd2 = xorshift32();
    rw  = 2'(xorshift32());
    if (instr[31:28] == T_CMP && rd1[1:0] == 2'b00)
      rd2 = rd1; // equal operands now and then
  endtask

  task automatic predict();
    logic [3:0]  ty;
    logic [3:0]  op;
    logic        sz;
    logic [31:0] ext;
    logic [31:0] simm;
    logic [31:0] off;
    ty   = ir[31:28];
    op   = ir[27:24];
    sz   = ir[0];
    ext  = ir[63:32];
    simm = {{17{ir[15]}}, ir[15:1]};
    off  = simm << 2;
    exp_ir     = ir;
    exp_rd1    = rd1;
    exp_rw     = rw;
    exp_pc     = pc;
    exp_pcset  = 1'b0;
    exp_exc    = 1'b0;
    exp_rvalid = 1'b1;
    case (ty)
      T_ALU:
        exp_result = alu_model(op[2:0], rd1, op[3] ? simm : rd2);
      T_CMP:
      begin
        exp_result = rd1 - rd2;
        m_ccr      = {rd1 < rd2, $signed(rd1) < $signed(rd2), rd1 == rd2};
      end
      T_INT, T_INTU:
        exp_result = int_model({ty == T_INTU, op[1:0]}, rd1, op[3] ? simm : rd2);
      T_LOAD, T_STORE:
        exp_result = sz ? ext : off + rd2;
      T_LDI:
        exp_result = sz ? ext : {17'h0, ir[15:1]};
      T_MOV:
        exp_result = rd1;
      T_BRANCH:
      begin
        exp_rvalid = 1'b0;
        if (cond_met(op, m_ccr))
        begin
          exp_pc    = pc + off;
          exp_pcset = 1'b1;
        end
      end
      T_JUMP:
      begin
        exp_rvalid = 1'b0;
        exp_pc     = sz ? ext : rd2 + off;
        exp_pcset  = 1'b1;
      end
      T_INH:
      begin
        exp_rvalid = 1'b0;
        case (op)
          4'h1:
            if (sz)
              m_base = ext;
            else
            begin
              exp_result = m_base + 32'd24 + 32'd8 * 32'(ir[2:1]); // trap vector
              exp_exc    = 1'b1;
              exp_rvalid = 1'b1;
            end
          4'h2: m_ie = 1'b0;
          4'h3: m_ie = 1'b1;
          4'h4: m_halt = 1'b1;
          4'h5:
          begin
            exp_result = m_base;
            exp_exc    = 1'b1;
            exp_rvalid = 1'b1;
          end
          default:
          begin
          end
        endcase
      end
      default:
        exp_rvalid = 1'b0;
    endcase
  endtask

  task automatic check_outputs();
    check("ir_o", ir_out, exp_ir);
    check("pc_o", 64'(pc_out), 64'(exp_pc));
    check("reg_data1_o", 64'(rd1_out), 64'(exp_rd1));
    check("reg_write_o", 64'(rw_out), 64'(exp_rw));
    check("ccr_o", 64'(ccr), 64'(m_ccr));
    check("pc_set_o", 64'(pc_set), 64'(exp_pcset));
    check("exc_o", 64'(exc), 64'(exp_exc));
    check("halt_o", 64'(halt), 64'(m_halt));
    check("interrupts_enabled_o", 64'(ie), 64'(m_ie));
    if (exp_rvalid)
      check("result_o", 64'(result), 64'(exp_result));
  endtask

  // entered and left at a falling edge
  task automatic run_single(input logic [63:0] instr, input int stall_cycles);
    drive(instr);
    if (stall_cycles > 0)
    begin
      stall = 1'b1;
      repeat (stall_cycles)
      begin
        @(negedge clk);
        check_outputs(); // model frozen while stalled
      end
      stall = 1'b0;
    end
    predict();
    @(negedge clk);
    check_outputs();
  endtask

  task automatic run_int(input logic [63:0] instr);
    int high;
    drive(instr);
    #1;
    if (stall_out !== 1'b1)
      fail_stop("stall_o did not rise when the integer instruction was presented");
    high = 1;
    @(negedge clk);
    while (stall_out === 1'b1)
    begin
      if (high >= 2 * INT_CYCLES)
        fail_stop("stall_o stayed high far beyond the integer latency");
      check_outputs();
      high++;
      @(negedge clk);
    end
    check_outputs(); // not captured until the next edge
    check("stall_o cycles", 64'(high), 64'(INT_CYCLES));
    predict();
    @(negedge clk);
    check_outputs();
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_stop("watchdog expired before the tests finished");
  end

  initial
  begin
    logic [63:0] w;
    logic [31:0] r;
    rng_state = 32'd79157;
    ir    = 64'h0;
    pc    = 32'h0;
    rd1   = 32'h0;
    rd2   = 32'h0;
    rw    = 2'h0;
    stall = 1'b0;
    @(negedge rst);
    #1;
    check("result_o after reset", 64'(result), 64'h0);
    check("reg_data1_o after reset", 64'(rd1_out), 64'h0);
    check("pc_o after reset", 64'(pc_out), 64'h0);
    check("ir_o after reset", ir_out, 64'h0);
    check("reg_write_o after reset", 64'(rw_out), 64'h0);
    check("ccr_o after reset", 64'(ccr), 64'h0);
    check("halt_o after reset", 64'(halt), 64'h0);
    check("stall_o after reset", 64'(stall_out), 64'h0);
    check("interrupts_enabled_o after reset", 64'(ie), 64'h0);
    check("exc_o after reset", 64'(exc), 64'h0);
    check("pc_set_o after reset", 64'(pc_set), 64'h0);
    m_ccr  = 3'h0;
    m_base = VECT_RESET;
    m_ie   = 1'b0;
    m_halt = 1'b0;
    @(negedge clk);

    for (int i = 0; i < N_SIMPLE; i++)
      run_single(rand_simple(1'b0), 0);

    for (int k = 0; k < N_BRANCH; k++)
    begin
      for (int c = 0; c <= 10; c++)
      begin
        run_single(make_instr(T_CMP, 4'h0), 0);
        run_single(make_instr(T_BRANCH, 4'(c)), 0);
      end
      for (int j = 0; j < 4; j++)
      begin
        w = make_instr(T_JUMP, 4'h0);
        w[0] = j[0]; // both target forms
        run_single(w, 0);
      end
    end

    for (int i = 0; i < N_INT; i++)
    begin
      r = xorshift32();
      w = make_instr(i[2] ? T_INTU : T_INT, {r[0], 1'b0, 2'(i)});
      if (i >= N_INT - 16)
        w = {w[63:28], 1'b1, w[26:16], 15'h0, w[0]}; // zero immediate divisor
      run_int(w);
    end

    for (int i = 0; i < N_STALL; i++)
    begin
      r = xorshift32();
      run_single(rand_simple(1'b1), r[2] ? int'(r[1:0]) + 1 : 0);
    end

    run_single(inh_instr(4'h1, 2'd0, 1'b1), 0); // setint
    for (int t = 0; t < 4; t++)
      run_single(inh_instr(4'h1, 2'(t), 1'b0), 0);
    run_single(inh_instr(4'h5, 2'd0, 1'b0), 0);
    run_single(inh_instr(4'h3, 2'd0, 1'b0), 0); // enable first so cli has an effect
    run_single(inh_instr(4'h2, 2'd0, 1'b0), 0);
    run_single(inh_instr(4'h3, 2'd0, 1'b0), 0);
    run_single(inh_instr(4'h4, 2'd0, 1'b0), 0);
    for (int i = 0; i < 3; i++)
      run_single(rand_simple(1'b1), 0);

    $display("Testbench passed");
    $finish;
  end

endmodule

//--- vlog.f
src/ex_pkg.sv
src/alu_if.sv
src/alu_comb.sv
src/int_calc.sv
src/execute.sv
src/ex_top.sv
dv/clk_gen.sv
dv/ex_checker.sv
dv/ex_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module ex_tb -f vlog.f -o ex_tb_sim
	./obj_dir/ex_tb_sim | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
